// File: rtl/motor_cfg_pkg.sv
// Timing constants assume a 50 MHz clock; stall limits are in clock cycles and sized for simulation
package motor_cfg_pkg;

	// --------------------------------------
	// Input conditioning
	// --------------------------------------

	// Counter width of the debounce stability counter
	localparam int DEJITTER_W = 16;

	// Cycles a new level must hold before it is accepted
	localparam logic [DEJITTER_W-1:0] DEJITTER_CLKS = 16'd16;

	// --------------------------------------
	// Stall limits per motor type
	// --------------------------------------

	// Longest tach gap for the fast motor on channel 1
	localparam logic [31:0] HIGH_SPEED_STALL_CLKS = 32'd400;

	// Slow motor on channel 2 tolerates twice the gap
	localparam logic [31:0] LOW_SPEED_STALL_CLKS = 32'd800;

	// --------------------------------------
	// Data widths
	// --------------------------------------

	// Period and duty settings
	localparam int PWM_W = 16;

	// Measured tach period
	localparam int SPEED_W = 32;

endpackage

// File: rtl/motor_state_pkg.sv
// Run state encoding is shared by the drive and the merge; the numeric order carries no meaning
package motor_state_pkg;

	// Channel run state
	// MS_OFF     switch low, drive idle
	// MS_SPINUP  switch high, waiting for two tach edges
	// MS_RUN     tach edges arriving inside the stall limit
	// MS_STALL   tach gap reached the limit, left only by switching off
	// MS_FAULT   alarm line high, PWM forced low
	typedef enum logic [2:0] {
		MS_OFF    = 3'd0,
		MS_SPINUP = 3'd1,
		MS_RUN    = 3'd2,
		MS_STALL  = 3'd3,
		MS_FAULT  = 3'd4
	} motor_state_e;

endpackage

// File: rtl/fg_debounce.sv
// Input is asynchronous and slow; pulses shorter than DEJITTER_CLKS cycles are dropped, latency 2 + DEJITTER_CLKS
`timescale 1ns/1ps

module fg_debounce #(
	parameter logic [motor_cfg_pkg::DEJITTER_W-1:0] DEJITTER_CLKS = motor_cfg_pkg::DEJITTER_CLKS
) (
	input  logic i_clk_50m,
	input  logic i_rst,
	input  logic i_signal,
	output logic o_signal
);

	// Last count value before the output flips
	localparam logic [motor_cfg_pkg::DEJITTER_W-1:0] CNT_LAST = DEJITTER_CLKS - 1'b1;

	logic                                  sync1_q;
	logic                                  sync2_q;
	logic [motor_cfg_pkg::DEJITTER_W-1:0]  cnt_q;

	// Two flop synchronizer
	// Stability counter runs only while the synced line differs from the output
	always_ff @(posedge i_clk_50m) begin
		if (i_rst) begin
			sync1_q  <= 1'b0;
			sync2_q  <= 1'b0;
			cnt_q    <= '0;
			o_signal <= 1'b0;
		end else begin
			sync1_q <= i_signal;
			sync2_q <= sync1_q;
			if (sync2_q == o_signal) begin
				// Glitch gone, start over
				cnt_q <= '0;
			end else if (cnt_q == CNT_LAST) begin
				cnt_q    <= '0;
				o_signal <= sync2_q;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Output only moves after a full stable window
	a_stable_window: assert property (@(posedge i_clk_50m) disable iff (i_rst)
		!$stable(o_signal) |-> ($past(cnt_q) == CNT_LAST));

endmodule

// File: rtl/motor_pwm_gen.sv
// Output is registered; period 0 gives constant low, duty >= period constant high, updates at period wrap
`timescale 1ns/1ps

module motor_pwm_gen (
	input  logic                              i_clk_50m,
	input  logic                              i_rst,
	input  logic                              i_enable,
	input  logic [motor_cfg_pkg::PWM_W-1:0]   i_period,
	input  logic [motor_cfg_pkg::PWM_W-1:0]   i_duty,
	output logic                              o_pwm,
	output logic [motor_cfg_pkg::PWM_W-1:0]   o_pwm_value
);

	logic [motor_cfg_pkg::PWM_W-1:0] cnt_q;
	logic [motor_cfg_pkg::PWM_W-1:0] cnt_d;
	logic [motor_cfg_pkg::PWM_W-1:0] per_q;
	logic [motor_cfg_pkg::PWM_W-1:0] per_d;
	logic [motor_cfg_pkg::PWM_W-1:0] duty_q;
	logic [motor_cfg_pkg::PWM_W-1:0] duty_d;
	logic                            wrap;
	logic                            pwm_d;

	// --------------------------------------
	// Counter and shadow update
	// --------------------------------------
	always_comb begin
		// Last cycle of the period, or no period at all
		wrap = (per_q == '0) || (cnt_q >= per_q - 1'b1);
		if (!i_enable || wrap) begin
			// Shadows pick up new settings as the count enters zero
			cnt_d  = '0;
			per_d  = i_period;
			duty_d = i_duty;
		end else begin
			cnt_d  = cnt_q + 1'b1;
			per_d  = per_q;
			duty_d = duty_q;
		end
		// High for the first duty counts of each period
		pwm_d = i_enable && (per_d != '0) && (cnt_d < duty_d);
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_rst) begin
			cnt_q  <= '0;
			per_q  <= '0;
			duty_q <= '0;
			o_pwm  <= 1'b0;
		end else begin
			cnt_q  <= cnt_d;
			per_q  <= per_d;
			duty_q <= duty_d;
			o_pwm  <= pwm_d;
		end
	end

	// Applied duty, not the requested one
	assign o_pwm_value = duty_q;

	// Drive is dead the cycle after enable drops
	a_off_low: assert property (@(posedge i_clk_50m) disable iff (i_rst)
		!i_enable |=> !o_pwm);

endmodule

// File: rtl/motor_drive.sv
// One channel; tach period counts rising FG edges only, stall and fault clear only by switching off
`timescale 1ns/1ps

module motor_drive #(
	parameter logic [31:0] STALL_CLKS = motor_cfg_pkg::HIGH_SPEED_STALL_CLKS
) (
	input  logic                                i_clk_50m,
	input  logic                                i_rst,
	input  logic                                i_motor_sw,
	input  logic                                i_motor_fg,
	input  logic                                i_motor_rd,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_freq_motor,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_motor_pwm_setval,
	output logic                                o_motor_pwm,
	output logic [motor_cfg_pkg::PWM_W-1:0]     o_pwm_value,
	output logic [motor_cfg_pkg::SPEED_W-1:0]   o_actual_speed,
	output motor_state_pkg::motor_state_e       o_motor_state
);

	logic                                 fg_db;
	logic                                 rd_db;
	logic                                 fg_db_q;
	logic                                 fg_rise;
	logic                                 fg_seen_q;
	logic                                 stall_hit;
	logic                                 pwm_en;
	logic [motor_cfg_pkg::SPEED_W-1:0]    gap_cnt_q;
	logic [motor_cfg_pkg::SPEED_W-1:0]    speed_q;
	motor_state_pkg::motor_state_e        state_q;
	motor_state_pkg::motor_state_e        state_d;

	// --------------------------------------
	// Input cleanup
	// --------------------------------------
	fg_debounce #(
		.DEJITTER_CLKS ( motor_cfg_pkg::DEJITTER_CLKS )
	) u_fg_debounce (
		.i_clk_50m     ( i_clk_50m  ),
		.i_rst         ( i_rst      ),
		.i_signal      ( i_motor_fg ),
		.o_signal      ( fg_db      )
	);

	fg_debounce #(
		.DEJITTER_CLKS ( motor_cfg_pkg::DEJITTER_CLKS )
	) u_rd_debounce (
		.i_clk_50m     ( i_clk_50m  ),
		.i_rst         ( i_rst      ),
		.i_signal      ( i_motor_rd ),
		.o_signal      ( rd_db      )
	);

	// Rising edge of the clean tach line
	assign fg_rise = fg_db && !fg_db_q;

	// Gap since last edge, or since switch-on before the first one
	assign stall_hit = (gap_cnt_q >= STALL_CLKS);

	// --------------------------------------
	// Tach period measurement
	// --------------------------------------
	always_ff @(posedge i_clk_50m) begin
		if (i_rst) begin
			fg_db_q   <= 1'b0;
			fg_seen_q <= 1'b0;
			gap_cnt_q <= '0;
			speed_q   <= '0;
		end else begin
			fg_db_q <= fg_db;
			if (state_q == motor_state_pkg::MS_OFF) begin
				gap_cnt_q <= '0;
				fg_seen_q <= 1'b0;
			end else if (fg_rise) begin
				// Count of 1 on the edge makes the next load equal the spacing
				gap_cnt_q <= motor_cfg_pkg::SPEED_W'(1);
				fg_seen_q <= 1'b1;
			end else if (gap_cnt_q != '1) begin
				gap_cnt_q <= gap_cnt_q + 1'b1;
			end
			if (fg_rise) begin
				speed_q <= gap_cnt_q;
			end
		end
	end

	// --------------------------------------
	// Run state FSM
	// --------------------------------------
	always_comb begin
		state_d = state_q;
		if (!i_motor_sw) begin
			state_d = motor_state_pkg::MS_OFF;
		end else if (rd_db) begin
			// Alarm wins over stall
			state_d = motor_state_pkg::MS_FAULT;
		end else begin
			case (state_q)
				motor_state_pkg::MS_OFF: state_d = motor_state_pkg::MS_SPINUP;
				motor_state_pkg::MS_SPINUP: begin
					if (stall_hit) begin
						state_d = motor_state_pkg::MS_STALL;
					end else if (fg_rise && fg_seen_q) begin
						// Second clean edge
						state_d = motor_state_pkg::MS_RUN;
					end
				end
				motor_state_pkg::MS_RUN: begin
					if (stall_hit) begin
						state_d = motor_state_pkg::MS_STALL;
					end
				end
				// Stall and fault hold until switch-off
				default: state_d = state_q;
			endcase
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_rst) begin
			state_q <= motor_state_pkg::MS_OFF;
		end else begin
			state_q <= state_d;
		end
	end

	// Alarm cuts the drive
	assign pwm_en = i_motor_sw && (state_q != motor_state_pkg::MS_FAULT);

	motor_pwm_gen u_pwm_gen (
		.i_clk_50m   ( i_clk_50m          ),
		.i_rst       ( i_rst              ),
		.i_enable    ( pwm_en             ),
		.i_period    ( i_freq_motor       ),
		.i_duty      ( i_motor_pwm_setval ),
		.o_pwm       ( o_motor_pwm        ),
		.o_pwm_value ( o_pwm_value        )
	);

	assign o_actual_speed = speed_q;
	assign o_motor_state  = state_q;

	// Run needs a spin-up phase first
	a_no_direct_run: assert property (@(posedge i_clk_50m) disable iff (i_rst)
		(state_q == motor_state_pkg::MS_OFF) |=> (state_q != motor_state_pkg::MS_RUN));

endmodule

// File: rtl/motor_status_merge.sv
// Outputs lag the channel states by one cycle; a fault on any channel also blocks measurement
`timescale 1ns/1ps

module motor_status_merge (
	input  logic                            i_clk_50m,
	input  logic                            i_rst,
	input  logic [1:0]                      i_motor_sw,
	input  motor_state_pkg::motor_state_e   i_state1,
	input  motor_state_pkg::motor_state_e   i_state2,
	output logic                            o_measure_en,
	output logic                            o_fault_any
);

	logic fault_d;
	logic ready1;
	logic ready2;

	// Stall or alarm on either side
	assign fault_d = (i_state1 == motor_state_pkg::MS_STALL) ||
	                 (i_state1 == motor_state_pkg::MS_FAULT) ||
	                 (i_state2 == motor_state_pkg::MS_STALL) ||
	                 (i_state2 == motor_state_pkg::MS_FAULT);

	// Switched-off channel does not hold up measurement
	assign ready1 = !i_motor_sw[0] || (i_state1 == motor_state_pkg::MS_RUN);
	assign ready2 = !i_motor_sw[1] || (i_state2 == motor_state_pkg::MS_RUN);

	always_ff @(posedge i_clk_50m) begin
		if (i_rst) begin
			o_measure_en <= 1'b0;
			o_fault_any  <= 1'b0;
		end else begin
			o_measure_en <= (|i_motor_sw) && ready1 && ready2 && !fault_d;
			o_fault_any  <= fault_d;
		end
	end

	// Never measure through a fault
	a_exclusive: assert property (@(posedge i_clk_50m) disable iff (i_rst)
		!(o_measure_en && o_fault_any));

endmodule

// File: rtl/motor_control.sv
// Channel 1 expects the fast motor and channel 2 the slow one; all inputs may be asynchronous
`timescale 1ns/1ps

module motor_control (
	input  logic                                i_clk_50m,
	input  logic                                i_rst,
	input  logic [1:0]                          i_motor_sw,
	input  logic                                i_motor_fg1,
	input  logic                                i_motor_fg2,
	input  logic                                i_motor_rd1,
	input  logic                                i_motor_rd2,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_freq_motor1,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_freq_motor2,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_motor_pwm_setval1,
	input  logic [motor_cfg_pkg::PWM_W-1:0]     i_motor_pwm_setval2,
	output logic                                o_motor_pwm1,
	output logic                                o_motor_pwm2,
	output logic [motor_cfg_pkg::PWM_W-1:0]     o_pwm_value1,
	output logic [motor_cfg_pkg::PWM_W-1:0]     o_pwm_value2,
	output logic [motor_cfg_pkg::SPEED_W-1:0]   o_actual_speed1,
	output logic [motor_cfg_pkg::SPEED_W-1:0]   o_actual_speed2,
	output motor_state_pkg::motor_state_e       o_motor_state1,
	output motor_state_pkg::motor_state_e       o_motor_state2,
	output logic                                o_measure_en,
	output logic                                o_fault_any
);

	// --------------------------------------
	// Channel 1, fast motor
	// --------------------------------------
	motor_drive #(
		.STALL_CLKS         ( motor_cfg_pkg::HIGH_SPEED_STALL_CLKS )
	) u1_motor_drive (
		.i_clk_50m          ( i_clk_50m           ),
		.i_rst              ( i_rst               ),
		.i_motor_sw         ( i_motor_sw[0]       ),
		.i_motor_fg         ( i_motor_fg1         ),
		.i_motor_rd         ( i_motor_rd1         ),
		.i_freq_motor       ( i_freq_motor1       ),
		.i_motor_pwm_setval ( i_motor_pwm_setval1 ),
		.o_motor_pwm        ( o_motor_pwm1        ),
		.o_pwm_value        ( o_pwm_value1        ),
		.o_actual_speed     ( o_actual_speed1     ),
		.o_motor_state      ( o_motor_state1      )
	);

	// --------------------------------------
	// Channel 2, slow motor
	// --------------------------------------
	motor_drive #(
		.STALL_CLKS         ( motor_cfg_pkg::LOW_SPEED_STALL_CLKS )
	) u2_motor_drive (
		.i_clk_50m          ( i_clk_50m           ),
		.i_rst              ( i_rst               ),
		.i_motor_sw         ( i_motor_sw[1]       ),
		.i_motor_fg         ( i_motor_fg2         ),
		.i_motor_rd         ( i_motor_rd2         ),
		.i_freq_motor       ( i_freq_motor2       ),
		.i_motor_pwm_setval ( i_motor_pwm_setval2 ),
		.o_motor_pwm        ( o_motor_pwm2        ),
		.o_pwm_value        ( o_pwm_value2        ),
		.o_actual_speed     ( o_actual_speed2     ),
		.o_motor_state      ( o_motor_state2      )
	);

	// Both states feed the summary
	motor_status_merge u_status_merge (
		.i_clk_50m          ( i_clk_50m      ),
		.i_rst              ( i_rst          ),
		.i_motor_sw         ( i_motor_sw     ),
		.i_state1           ( o_motor_state1 ),
		.i_state2           ( o_motor_state2 ),
		.o_measure_en       ( o_measure_en   ),
		.o_fault_any        ( o_fault_any    )
	);

endmodule

// File: test/motor_control_tb.sv
// Checks are flag-gated assertions; tach models are ideal square waves driven 1 ns after the clock
`timescale 1ns/1ps

module motor_control_tb;

	localparam int CYCLE_LIMIT = 12000;
	localparam int PWM_PERIOD  = 20;
	// Channel 2 duty during the speed test
	localparam int DUTY2       = 12;
	// Worst case from FG stop to stall on channel 2
	localparam int STALL_LIMIT = int'(motor_cfg_pkg::LOW_SPEED_STALL_CLKS) +
	                             int'(motor_cfg_pkg::DEJITTER_CLKS) + 4;

	logic                                i_clk_50m;
	logic                                i_rst;
	logic [1:0]                          i_motor_sw;
	logic                                i_motor_fg1;
	logic                                i_motor_fg2;
	logic                                i_motor_rd1;
	logic                                i_motor_rd2;
	logic [motor_cfg_pkg::PWM_W-1:0]     i_freq_motor1;
	logic [motor_cfg_pkg::PWM_W-1:0]     i_freq_motor2;
	logic [motor_cfg_pkg::PWM_W-1:0]     i_motor_pwm_setval1;
	logic [motor_cfg_pkg::PWM_W-1:0]     i_motor_pwm_setval2;
	logic                                o_motor_pwm1;
	logic                                o_motor_pwm2;
	logic [motor_cfg_pkg::PWM_W-1:0]     o_pwm_value1;
	logic [motor_cfg_pkg::PWM_W-1:0]     o_pwm_value2;
	logic [motor_cfg_pkg::SPEED_W-1:0]   o_actual_speed1;
	logic [motor_cfg_pkg::SPEED_W-1:0]   o_actual_speed2;
	motor_state_pkg::motor_state_e       o_motor_state1;
	motor_state_pkg::motor_state_e       o_motor_state2;
	logic                                o_measure_en;
	logic                                o_fault_any;

	// Check enables, set by the stimulus
	string                               test_name;
	logic                                checks_on;
	logic                                pwm_armed;
	logic                                const_hi;
	logic                                speed_chk;
	logic                                stall_arm;
	logic                                glitch_chk;
	logic                                rst_d;
	logic                                pwm1_q;
	logic                                fault_exp_q;
	logic                                meas_exp_q;
	logic                                fault_expect;
	logic                                meas_expect;
	logic [motor_cfg_pkg::PWM_W-1:0]     duty_sel;
	int unsigned                         hi_cnt;
	int unsigned                         per_cnt;
	int unsigned                         stall_wait;
	int unsigned                         cycle_cnt;
	int unsigned                         fg1_per;
	int unsigned                         fg1_ph;
	int unsigned                         fg2_per;
	int unsigned                         fg2_ph;

	motor_control u_dut (
		.i_clk_50m           ( i_clk_50m           ),
		.i_rst               ( i_rst               ),
		.i_motor_sw          ( i_motor_sw          ),
		.i_motor_fg1         ( i_motor_fg1         ),
		.i_motor_fg2         ( i_motor_fg2         ),
		.i_motor_rd1         ( i_motor_rd1         ),
		.i_motor_rd2         ( i_motor_rd2         ),
		.i_freq_motor1       ( i_freq_motor1       ),
		.i_freq_motor2       ( i_freq_motor2       ),
		.i_motor_pwm_setval1 ( i_motor_pwm_setval1 ),
		.i_motor_pwm_setval2 ( i_motor_pwm_setval2 ),
		.o_motor_pwm1        ( o_motor_pwm1        ),
		.o_motor_pwm2        ( o_motor_pwm2        ),
		.o_pwm_value1        ( o_pwm_value1        ),
		.o_pwm_value2        ( o_pwm_value2        ),
		.o_actual_speed1     ( o_actual_speed1     ),
		.o_actual_speed2     ( o_actual_speed2     ),
		.o_motor_state1      ( o_motor_state1      ),
		.o_motor_state2      ( o_motor_state2      ),
		.o_measure_en        ( o_measure_en        ),
		.o_fault_any         ( o_fault_any         )
	);

	initial begin
		i_clk_50m = 1'b0;
		forever #2 i_clk_50m = ~i_clk_50m;
	end

	// --------------------------------------
	// Failure reporting and helpers
	// --------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input longint expected, input longint actual);
		report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge i_clk_50m);
		#1;
	endtask

	task automatic start_fg(input int ch, input int unsigned period);
		if (ch == 1) begin
			fg1_ph  = 0;
			fg1_per = period;
		end else begin
			fg2_ph  = 0;
			fg2_per = period;
		end
	endtask

	task automatic stop_fg(input int ch);
		if (ch == 1) begin
			fg1_per = 0;
		end else begin
			fg2_per = 0;
		end
	endtask

	task automatic wait_for_state(input int ch, input motor_state_pkg::motor_state_e st);
		while (((ch == 1) ? o_motor_state1 : o_motor_state2) != st) begin
			wait_cycles(1);
		end
	endtask

	// --------------------------------------
	// Tach models, half high half low
	// --------------------------------------
	always @(posedge i_clk_50m) begin
		#1;
		if (fg1_per == 0) begin
			i_motor_fg1 = 1'b0;
		end else begin
			i_motor_fg1 = (fg1_ph < fg1_per / 2);
			fg1_ph      = (fg1_ph == fg1_per - 1) ? 0 : fg1_ph + 1;
		end
	end

	always @(posedge i_clk_50m) begin
		#1;
		if (fg2_per == 0) begin
			i_motor_fg2 = 1'b0;
		end else begin
			i_motor_fg2 = (fg2_ph < fg2_per / 2);
			fg2_ph      = (fg2_ph == fg2_per - 1) ? 0 : fg2_ph + 1;
		end
	end

	// --------------------------------------
	// Reference model and monitors
	// --------------------------------------
	// Any channel stalled or alarmed
	assign fault_expect = (o_motor_state1 == motor_state_pkg::MS_STALL) ||
	                      (o_motor_state1 == motor_state_pkg::MS_FAULT) ||
	                      (o_motor_state2 == motor_state_pkg::MS_STALL) ||
	                      (o_motor_state2 == motor_state_pkg::MS_FAULT);
	// Every enabled channel running, at least one enabled
	assign meas_expect = (|i_motor_sw) && !fault_expect &&
	                     (!i_motor_sw[0] || (o_motor_state1 == motor_state_pkg::MS_RUN)) &&
	                     (!i_motor_sw[1] || (o_motor_state2 == motor_state_pkg::MS_RUN));

	always @(posedge i_clk_50m) begin
		rst_d       <= i_rst;
		fault_exp_q <= fault_expect;
		meas_exp_q  <= meas_expect;
		stall_wait  <= stall_arm ? stall_wait + 1 : 0;
		pwm1_q      <= o_motor_pwm1;
		// High count and length of each PWM period, restarted on the rising edge
		if (o_motor_pwm1 && !pwm1_q) begin
			hi_cnt  <= 1;
			per_cnt <= 1;
		end else begin
			hi_cnt  <= hi_cnt + o_motor_pwm1;
			per_cnt <= per_cnt + 1;
		end
	end

	// Run length guard
	always @(posedge i_clk_50m) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			report_failure("Timeout: the tests did not complete within the cycle limit");
		end
	end

	// --------------------------------------
	// Checks
	// --------------------------------------
	a_reset_out: assert property (@(posedge i_clk_50m)
		rst_d |-> ({o_motor_pwm1, o_motor_pwm2, o_measure_en, o_fault_any} == 4'b0000))
		else report_mismatch("reset outputs", 0,
			$sampled({o_motor_pwm1, o_motor_pwm2, o_measure_en, o_fault_any}));
	a_reset_state: assert property (@(posedge i_clk_50m) rst_d |->
		(o_motor_state1 == motor_state_pkg::MS_OFF) && (o_motor_state2 == motor_state_pkg::MS_OFF))
		else report_mismatch("reset state", motor_state_pkg::MS_OFF,
			$sampled(o_motor_state1) | $sampled(o_motor_state2));
	a_reset_speed: assert property (@(posedge i_clk_50m)
		rst_d |-> (o_actual_speed1 == '0) && (o_actual_speed2 == '0))
		else report_mismatch("reset speed", 0, $sampled(o_actual_speed1 | o_actual_speed2));

	a_pwm_high: assert property (@(posedge i_clk_50m)
		pwm_armed && $rose(o_motor_pwm1) |-> (hi_cnt == duty_sel))
		else report_mismatch("pwm high cycles", duty_sel, $sampled(hi_cnt));
	a_pwm_period: assert property (@(posedge i_clk_50m)
		pwm_armed && $rose(o_motor_pwm1) |-> (per_cnt == PWM_PERIOD))
		else report_mismatch("pwm period", PWM_PERIOD, $sampled(per_cnt));
	a_pwm_value: assert property (@(posedge i_clk_50m) pwm_armed |-> (o_pwm_value1 == duty_sel))
		else report_mismatch("pwm value", duty_sel, $sampled(o_pwm_value1));
	a_pwm_full: assert property (@(posedge i_clk_50m) const_hi |-> o_motor_pwm1)
		else report_mismatch("pwm full duty", 1, $sampled(o_motor_pwm1));
	a_pwm_off1: assert property (@(posedge i_clk_50m) checks_on && !i_motor_sw[0] |=> !o_motor_pwm1)
		else report_mismatch("pwm off ch1", 0, $sampled(o_motor_pwm1));
	a_pwm_off2: assert property (@(posedge i_clk_50m) checks_on && !i_motor_sw[1] |=> !o_motor_pwm2)
		else report_mismatch("pwm off ch2", 0, $sampled(o_motor_pwm2));

	a_speed1: assert property (@(posedge i_clk_50m) speed_chk |-> (o_actual_speed1 == 100))
		else report_mismatch("speed ch1", 100, $sampled(o_actual_speed1));
	a_speed2: assert property (@(posedge i_clk_50m) speed_chk |-> (o_actual_speed2 == 150))
		else report_mismatch("speed ch2", 150, $sampled(o_actual_speed2));
	a_pwm_value2: assert property (@(posedge i_clk_50m) speed_chk |-> (o_pwm_value2 == DUTY2))
		else report_mismatch("pwm value ch2", DUTY2, $sampled(o_pwm_value2));
	a_run_both: assert property (@(posedge i_clk_50m) speed_chk |->
		(o_motor_state1 == motor_state_pkg::MS_RUN) && (o_motor_state2 == motor_state_pkg::MS_RUN))
		else report_mismatch("run state", motor_state_pkg::MS_RUN,
			($sampled(o_motor_state1) == motor_state_pkg::MS_RUN) ?
			$sampled(o_motor_state2) : $sampled(o_motor_state1));

	// Merge outputs lag their inputs by one cycle
	a_measure: assert property (@(posedge i_clk_50m) checks_on |-> (o_measure_en == meas_exp_q))
		else report_mismatch({test_name, " measure enable"}, $sampled(meas_exp_q),
			$sampled(o_measure_en));
	a_fault: assert property (@(posedge i_clk_50m) checks_on |-> (o_fault_any == fault_exp_q))
		else report_mismatch({test_name, " fault summary"}, $sampled(fault_exp_q),
			$sampled(o_fault_any));
	a_spinup_block: assert property (@(posedge i_clk_50m) checks_on && i_motor_sw[1] &&
		(o_motor_state2 == motor_state_pkg::MS_SPINUP) |=> !o_measure_en)
		else report_mismatch("measure during spin-up", 0, $sampled(o_measure_en));

	a_stall_time: assert property (@(posedge i_clk_50m) stall_arm &&
		(o_motor_state2 != motor_state_pkg::MS_STALL) |-> (stall_wait < STALL_LIMIT))
		else report_mismatch("stall delay", STALL_LIMIT, $sampled(stall_wait));
	a_off1: assert property (@(posedge i_clk_50m) checks_on && !i_motor_sw[0] |=>
		(o_motor_state1 == motor_state_pkg::MS_OFF))
		else report_mismatch("switch off ch1", motor_state_pkg::MS_OFF, $sampled(o_motor_state1));
	a_off2: assert property (@(posedge i_clk_50m) checks_on && !i_motor_sw[1] |=>
		(o_motor_state2 == motor_state_pkg::MS_OFF))
		else report_mismatch("switch off ch2", motor_state_pkg::MS_OFF, $sampled(o_motor_state2));

	a_glitch: assert property (@(posedge i_clk_50m) glitch_chk |->
		(o_motor_state1 == motor_state_pkg::MS_RUN))
		else report_mismatch("alarm glitch", motor_state_pkg::MS_RUN, $sampled(o_motor_state1));
	a_fault_pwm: assert property (@(posedge i_clk_50m)
		(o_motor_state1 == motor_state_pkg::MS_FAULT) |=> !o_motor_pwm1)
		else report_mismatch("alarm pwm", 0, $sampled(o_motor_pwm1));

	// --------------------------------------
	// Stimulus
	// --------------------------------------
	initial begin
		int unsigned wait_n;
		int unsigned glitch_w;
		void'($urandom(32'h8802));
		i_rst = 1'b1;
		i_motor_sw = 2'b00;
		i_motor_fg1 = 1'b0;
		i_motor_fg2 = 1'b0;
		i_motor_rd1 = 1'b0;
		i_motor_rd2 = 1'b0;
		i_freq_motor1 = '0;
		i_freq_motor2 = '0;
		i_motor_pwm_setval1 = '0;
		i_motor_pwm_setval2 = '0;
		{checks_on, pwm_armed, const_hi, speed_chk, stall_arm, glitch_chk} = '0;
		{rst_d, pwm1_q, fault_exp_q, meas_exp_q} = '0;
		{hi_cnt, per_cnt, stall_wait, cycle_cnt} = '0;
		{fg1_per, fg1_ph, fg2_per, fg2_ph} = '0;
		duty_sel = '0;
		test_name = "reset";
		wait_cycles(10);
		i_rst = 1'b0;
		wait_cycles(2);
		checks_on = 1'b1;

		// Random duty on a 20 cycle period, then full duty, then off
		test_name = "pwm";
		duty_sel = motor_cfg_pkg::PWM_W'(1 + $urandom % (PWM_PERIOD - 1));
		i_freq_motor1 = motor_cfg_pkg::PWM_W'(PWM_PERIOD);
		i_motor_pwm_setval1 = duty_sel;
		i_motor_sw = 2'b01;
		// First rise and the short first period are not full periods
		while (!o_motor_pwm1) begin
			wait_cycles(1);
		end
		while (o_motor_pwm1) begin
			wait_cycles(1);
		end
		while (!o_motor_pwm1) begin
			wait_cycles(1);
		end
		wait_cycles(1);
		pwm_armed = 1'b1;
		wait_cycles(3 * PWM_PERIOD + 2);
		pwm_armed = 1'b0;
		i_motor_pwm_setval1 = 16'd25;
		wait_cycles(PWM_PERIOD + 5);
		const_hi = 1'b1;
		wait_cycles(2 * PWM_PERIOD);
		const_hi = 1'b0;
		i_motor_sw = 2'b00;
		wait_cycles(PWM_PERIOD);

		test_name = "speed";
		i_motor_pwm_setval1 = 16'd10;
		i_freq_motor2 = 16'd30;
		i_motor_pwm_setval2 = motor_cfg_pkg::PWM_W'(DUTY2);
		start_fg(1, 100);
		start_fg(2, 150);
		i_motor_sw = 2'b11;
		wait_for_state(1, motor_state_pkg::MS_RUN);
		wait_for_state(2, motor_state_pkg::MS_RUN);
		speed_chk = 1'b1;
		wait_cycles(300);
		speed_chk = 0;

		// Channel 2 off and back on through spin-up
		test_name = "measure enable";
		while (!o_measure_en) begin
			wait_cycles(1);
		end
		i_motor_sw = 2'b01;
		wait_cycles(50);
		i_motor_sw = 2'b11;
		wait_for_state(2, motor_state_pkg::MS_RUN);
		while (!o_measure_en) begin
			wait_cycles(1);
		end
		wait_cycles(20);

		test_name = "stall";
		stop_fg(2);
		stall_arm = 1'b1;
		wait_for_state(2, motor_state_pkg::MS_STALL);
		stall_arm = 1'b0;
		wait_cycles(10);
		i_motor_sw = 2'b01;
		wait_for_state(2, motor_state_pkg::MS_OFF);
		wait_cycles(10);

		// Short RD pulse first, then a held alarm
		test_name = "alarm";
		wait_n = $urandom % 100;
		glitch_w = 4 + $urandom % 10;
		wait_cycles(wait_n);
		glitch_chk = 1'b1;
		i_motor_rd1 = 1'b1;
		wait_cycles(glitch_w);
		i_motor_rd1 = 1'b0;
		wait_cycles(40);
		glitch_chk = 1'b0;
		i_motor_rd1 = 1'b1;
		wait_for_state(1, motor_state_pkg::MS_FAULT);
		wait_cycles(30);
		i_motor_rd1 = 1'b0;
		i_motor_sw = 2'b00;
		stop_fg(1);
		wait_for_state(1, motor_state_pkg::MS_OFF);
		wait_cycles(5);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: motor_control.f
rtl/motor_cfg_pkg.sv
rtl/motor_state_pkg.sv
rtl/fg_debounce.sv
rtl/motor_pwm_gen.sv
rtl/motor_drive.sv
rtl/motor_status_merge.sv
rtl/motor_control.sv
test/motor_control_tb.sv

// File: Bender.yml
package:
  name: motor_control

sources:
  # Packages first, then leaf modules up to the top level
  - rtl/motor_cfg_pkg.sv
  - rtl/motor_state_pkg.sv
  - rtl/fg_debounce.sv
  - rtl/motor_pwm_gen.sv
  - rtl/motor_drive.sv
  - rtl/motor_status_merge.sv
  - rtl/motor_control.sv

  # Testbench
  - target: test
    files:
      - test/motor_control_tb.sv
